// File: flist.f
+incdir+verif
hdl/synth_pkg.sv
hdl/audio_pkg.sv
hdl/host_write_port.sv
hdl/voice_regs.sv
hdl/tone_gen.sv
hdl/i2s_tx.sv
hdl/synth_top.sv
verif/tb_synth_top.sv

// File: verif/synth_model.svh
`ifndef SYNTH_MODEL_SVH
`define SYNTH_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of registers, phases and mix
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
int model_inc   [NUM_VOICES];
int model_wave  [NUM_VOICES];
int model_vol   [NUM_VOICES];
int model_phase [NUM_VOICES];
int model_pan;

task automatic clear_model_state();
    for (int v = 0; v < NUM_VOICES; v++) begin
        model_inc[v]   = 0;
        model_wave[v]  = 0;
        model_vol[v]   = 0;
        model_phase[v] = 0;
    end
    model_pan = 0;
endtask

task automatic apply_reg_write(input int addr, input int data);
    case (addr)
        REG_V0_INC, REG_V1_INC: begin
            model_inc[addr / 2] = data & 16'hffff;
        end
        REG_V0_CTL, REG_V1_CTL: begin
            model_wave[addr / 2] = data & 3;
            model_vol[addr / 2]  = (data >> 2) & 15;
        end
        REG_PAN: begin
            model_pan = data & 15;
        end
        default: begin
        end                                 // Unmapped addresses ignored
    endcase
endtask

function automatic int wave_value(input int wave, input int phase);
    int fold;
    fold = 2 * (phase % 32768);
    if (phase >= 32768) begin
        fold = 65535 - fold;                // Falling half of triangle
    end
    case (wave)
        WAVE_SQUARE:   return (phase >= 32768) ? -32768 : 32767;
        WAVE_SAW:      return phase - 32768;
        WAVE_TRIANGLE: return fold - 32768;
        default:       return 0;
    endcase
endfunction

// One frame step, phases first, then mix on new phases
task automatic advance_and_mix(output int left, output int right);
    int contrib;
    left  = 0;
    right = 0;
    for (int v = 0; v < NUM_VOICES; v++) begin
        model_phase[v] = (model_phase[v] + model_inc[v]) % 65536;
        contrib = wave_value(model_wave[v], model_phase[v]) * model_vol[v];
        if (model_pan[2 * v]) begin
            left += contrib;
        end
        if (model_pan[2 * v + 1]) begin
            right += contrib;
        end
    end
endtask

`endif

// File: verif/tb_synth_top.sv
`timescale 1ns/10ps

module tb_synth_top;
    import synth_pkg::*;
    import audio_pkg::*;

    localparam int TOTAL_FRAMES   = 50;
    localparam int TIMEOUT_CYCLES = 60 * FRAME_CYCLES + 200;
    localparam int MODE_ANY       = 0;
    localparam int MODE_LEFT_ONLY = 1;
    localparam int MODE_SILENT    = 2;

    logic        clk;
    logic        arst_n;
    logic        wr_valid;
    host_write_t wr;
    logic        wr_credit;
    logic        sclk;
    logic        ws;
    logic        sd;

    integer      seed           = 32'hec2a;
    int          credits        = WR_CREDITS;
    int          credit_pulses  = 0;
    int          writes_sent    = 0;
    int          cycle_count    = 0;
    int          frame_idx      = 0;
    int          frames_checked = 0;
    int          bit_pos        = 0;
    int          burst_mode     = MODE_ANY;
    logic        ws_prev;
    stereo_t     rx;
    host_write_t write_q [$];
    int          pred_l_q [$];
    int          pred_r_q [$];
    int          mode_q [$];

    `include "synth_model.svh"

    synth_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic compare(input logic signed [63:0] actual, input logic signed [63:0] expected,
                           input string message);
        if (actual !== expected) begin
            $display("FAIL @ %0t ns: %s (got %0d, expected %0d)", $time, message, actual,
                     expected);
            $display("STATUS: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic queue_write(input int addr, input int data);
        host_write_t w;
        w.addr = addr[ADDR_W-1:0];
        w.data = data[DATA_W-1:0];
        write_q.push_back(w);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Burst per frame at the start of the right slot
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic queue_burst(input int f);
        int n;
        n = (credits < 4) ? credits : 4;
        burst_mode  = MODE_ANY;
        if (f == 0) begin
            queue_write(REG_V0_INC, rand_below(65536));
            queue_write(REG_V0_CTL, 16'h003d);          // Square at volume 15
            queue_write(REG_V1_INC, rand_below(65536));
            queue_write(REG_PAN, 16'h0001);             // Voice 0 left only
            burst_mode = MODE_LEFT_ONLY;
        end else if (f < 10) begin
            queue_write(REG_V0_INC, rand_below(65536));
            burst_mode = MODE_LEFT_ONLY;
        end else if (f == 40) begin
            for (int i = 0; i < n; i++) begin
                queue_write(5 + rand_below(11), rand_below(65536));
            end
        end else if (f == 41) begin
            queue_write(REG_V0_CTL, 16'h003c);          // Off at full volume
            queue_write(REG_V1_CTL, 16'h0002);          // Saw at volume 0
            burst_mode = MODE_SILENT;
        end else if (f == 42) begin
            queue_write(REG_V0_CTL, 16'h0026);
            queue_write(REG_V1_CTL, 16'h001f);
            queue_write(REG_PAN, 16'h0000);
            burst_mode = MODE_SILENT;
        end else if (f >= 10 && f < 48) begin
            for (int i = 0; i < n; i++) begin
                queue_write(rand_below(5), rand_below(65536));
            end
        end
    endtask

    // I2S deserializer for cycles with sclk high
    task automatic take_serial_bit();
        int mode;
        compare(ws, bit_pos >= SLOT_BITS, "ws level within frame");
        if (bit_pos % SLOT_BITS < SAMPLE_W) begin
            if (bit_pos < SLOT_BITS) begin
                rx.left = {rx.left[SAMPLE_W-2:0], sd};
            end else begin
                rx.right = {rx.right[SAMPLE_W-2:0], sd};
            end
        end else begin
            compare(sd, 0, "slot padding bit");
        end
        if (bit_pos == 2 * SLOT_BITS - 1) begin
            mode = mode_q.pop_front();
            compare(rx.left, pred_l_q.pop_front(),
                    $sformatf("left, frame %0d", frames_checked));
            compare(rx.right, pred_r_q.pop_front(),
                    $sformatf("right, frame %0d", frames_checked));
            if (mode != MODE_ANY) begin
                compare(rx.right, 0, "right channel silent");
            end
            if (mode == MODE_SILENT) begin
                compare(rx.left, 0, "left channel silent");
            end
            frames_checked++;
        end
        bit_pos = (bit_pos + 1) % (2 * SLOT_BITS);
    endtask

    task automatic run_cycle();
        int exp_l;
        int exp_r;
        host_write_t w;
        @(negedge clk);
        if (wr_credit) begin
            credits++;
            credit_pulses++;
        end
        if (!ws && ws_prev) begin                       // Frame start edge passed
            advance_and_mix(exp_l, exp_r);
            pred_l_q.push_back(exp_l);
            pred_r_q.push_back(exp_r);
            mode_q.push_back(burst_mode);
            frame_idx++;
        end
        if (ws && !ws_prev) begin
            queue_burst(frame_idx);
        end
        ws_prev = ws;
        if (sclk) begin
            take_serial_bit();
        end
        if (write_q.size() > 0 && credits > 0) begin
            w = write_q.pop_front();
            wr_valid = 1'b1;
            wr       = w;
            credits--;
            writes_sent++;
            apply_reg_write(w.addr, w.data);
            if (write_q.size() == 0 && frame_idx == 0) begin
                // First two writes drained by the fourth
                compare(credit_pulses, WR_CREDITS - 2, "credits returned during first burst");
            end
        end else begin
            wr_valid = 1'b0;
            wr       = '0;
        end
        compare(credits >= 0 && credits <= WR_CREDITS, 1, "credit count in range");
    endtask

    initial begin
        arst_n   = 1'b0;
        wr_valid = 1'b0;
        wr       = '0;
        ws_prev  = 1'b0;
        rx       = '0;
        clear_model_state();
        repeat (2) begin                                // Reset frames shift zeros
            pred_l_q.push_back(0);
            pred_r_q.push_back(0);
            mode_q.push_back(MODE_SILENT);
        end
        repeat (5) begin
            @(negedge clk);
            compare(wr_credit, 0, "wr_credit in reset");
            compare(sclk, 0, "sclk in reset");
            compare(ws, 0, "ws in reset");
            compare(sd, 0, "sd in reset");
        end
        arst_n = 1'b1;
        while (frames_checked < TOTAL_FRAMES) begin
            run_cycle();
        end
        compare(credit_pulses, writes_sent, "credit pulses versus writes");
        compare(credits, WR_CREDITS, "credits after drain");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: hdl/synth_top.sv
`timescale 1ns/10ps

module synth_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wr_valid,
    input  synth_pkg::host_write_t wr,
    output logic                   wr_credit,
    output logic                   sclk,
    output logic                   ws,
    output logic                   sd
);
    import synth_pkg::*;
    import audio_pkg::*;

    logic              reg_valid;
    host_write_t       reg_wr;
    voice_cfg_t        voice_cfg [NUM_VOICES];
    logic [PAN_W-1:0]  pan;
    logic              frame_start;
    stereo_t           sample;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    host_write_port host_write_port (.*);

    voice_regs voice_regs (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Audio side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    tone_gen tone_gen (.*);     // One sample per frame_start

    i2s_tx i2s_tx (.*);

endmodule

// File: hdl/i2s_tx.sv
`timescale 1ns/10ps

module i2s_tx (
    input  logic               clk,
    input  logic               arst_n,
    input  audio_pkg::stereo_t sample,
    output logic               frame_start,
    output logic               sclk,
    output logic               ws,
    output logic               sd
);
    import audio_pkg::*;

    logic [FRAME_CNT_W-1:0] cnt;
    logic [2*SLOT_BITS-1:0] shreg;
    logic                   last_cycle;
    logic                   sclk_fall;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign last_cycle  = (cnt == FRAME_CNT_W'(FRAME_CYCLES - 1));
    assign sclk_fall   = cnt[0];                // sclk high now, low next
    assign sclk        = cnt[0];
    assign ws          = cnt[FRAME_CNT_W-1];    // Low = left slot
    assign frame_start = last_cycle;            // Cycle before ws falls

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shreg <= '0;
        end else if (last_cycle) begin
            shreg <= {sample.left, {PAD_BITS{1'b0}},
                      sample.right, {PAD_BITS{1'b0}}};  // Load as ws falls
        end else if (sclk_fall) begin
            shreg <= {shreg[2*SLOT_BITS-2:0], 1'b0};
        end
    end

    assign sd = shreg[2*SLOT_BITS-1];    // MSB first

endmodule

// File: hdl/tone_gen.sv
`timescale 1ns/10ps

module tone_gen (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        frame_start,
    input  synth_pkg::voice_cfg_t       voice_cfg [synth_pkg::NUM_VOICES],
    input  logic [synth_pkg::PAN_W-1:0] pan,
    output audio_pkg::stereo_t          sample
);
    import synth_pkg::*;
    import audio_pkg::*;

    localparam int MSB = PHASE_W - 1;

    logic [PHASE_W-1:0]          phase     [NUM_VOICES];
    logic [PHASE_W-1:0]          phase_nxt [NUM_VOICES];
    logic [PHASE_W-1:0]          tri_fold  [NUM_VOICES];
    logic signed [PHASE_W-1:0]   wave_val  [NUM_VOICES];
    logic signed [CONTRIB_W-1:0] contrib   [NUM_VOICES];
    sample_t                     mix_l;
    sample_t                     mix_r;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Waveform shaping on the advanced phase
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            phase_nxt[v] = phase[v] + voice_cfg[v].inc;    // 16-bit wrap
            tri_fold[v]  = {phase_nxt[v][MSB-1:0], 1'b0};
            if (phase_nxt[v][MSB]) begin
                tri_fold[v] = ~tri_fold[v];                 // Falling half
            end

            case (voice_cfg[v].wave)
                WAVE_SQUARE: begin
                    wave_val[v] = phase_nxt[v][MSB] ? {1'b1, {MSB{1'b0}}}
                                                    : {1'b0, {MSB{1'b1}}};
                end
                WAVE_SAW: begin
                    wave_val[v] = {~phase_nxt[v][MSB], phase_nxt[v][MSB-1:0]};
                end
                WAVE_TRIANGLE: begin
                    wave_val[v] = {~tri_fold[v][MSB], tri_fold[v][MSB-1:0]};
                end
                default: begin
                    wave_val[v] = '0;                       // WAVE_OFF
                end
            endcase

            contrib[v] = wave_val[v] * $signed({1'b0, voice_cfg[v].volume});
        end
    end

    // Pan routing, bit 2v left and 2v+1 right
    always_comb begin
        mix_l = '0;
        mix_r = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (pan[2*v]) begin
                mix_l = mix_l + contrib[v];
            end
            if (pan[2*v+1]) begin
                mix_r = mix_r + contrib[v];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase  <= '{default: '0};
            sample <= '0;
        end else if (frame_start) begin
            phase        <= phase_nxt;
            sample.left  <= mix_l;
            sample.right <= mix_r;
        end
    end

endmodule

// File: hdl/voice_regs.sv
`timescale 1ns/10ps

module voice_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   reg_valid,
    input  synth_pkg::host_write_t reg_wr,
    output synth_pkg::voice_cfg_t  voice_cfg [synth_pkg::NUM_VOICES],
    output logic [synth_pkg::PAN_W-1:0] pan
);
    import synth_pkg::*;

    // Control word into an existing voice setting
    function automatic voice_cfg_t apply_ctl(
        input voice_cfg_t        cfg,
        input logic [DATA_W-1:0] d
    );
        voice_cfg_t result;
        result        = cfg;
        result.wave   = wave_e'(d[1:0]);
        result.volume = d[VOL_W+1:2];
        return result;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                voice_cfg[v] <= '0;
            end
            pan <= '0;
        end else if (reg_valid) begin
            case (reg_addr_e'(reg_wr.addr))
                REG_V0_INC: begin
                    voice_cfg[0].inc <= reg_wr.data;
                end
                REG_V0_CTL: begin
                    voice_cfg[0] <= apply_ctl(voice_cfg[0], reg_wr.data);
                end
                REG_V1_INC: begin
                    voice_cfg[1].inc <= reg_wr.data;
                end
                REG_V1_CTL: begin
                    voice_cfg[1] <= apply_ctl(voice_cfg[1], reg_wr.data);
                end
                REG_PAN: begin
                    pan <= reg_wr.data[PAN_W-1:0];
                end
                default: begin
                    // Unmapped, dropped
                end
            endcase
        end
    end

endmodule

// File: hdl/host_write_port.sv
`timescale 1ns/10ps

module host_write_port (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wr_valid,
    input  synth_pkg::host_write_t wr,
    output logic                   wr_credit,
    output logic                   reg_valid,
    output synth_pkg::host_write_t reg_wr
);
    import synth_pkg::*;

    host_write_t         queue [WR_CREDITS];
    logic [WR_PTR_W-1:0] wr_ptr;
    logic [WR_PTR_W-1:0] rd_ptr;
    logic [WR_CNT_W-1:0] count;
    logic                pop;

    // Host never pushes without a credit, so no full check
    assign pop = (count != '0);

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            queue[wr_ptr] <= wr;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            reg_wr <= queue[rd_ptr];    // Head entry out
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers, occupancy and credit return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            reg_valid <= 1'b0;
            wr_credit <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count + WR_CNT_W'(wr_valid) - WR_CNT_W'(pop);
            reg_valid <= pop;
            wr_credit <= pop;               // One credit per drained entry
        end
    end

endmodule

// File: hdl/audio_pkg.sv
package audio_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sample format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int SAMPLE_W = 24;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // I2S frame layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int SLOT_BITS    = 32;                       // sclk periods per channel
    localparam int PAD_BITS     = SLOT_BITS - SAMPLE_W;     // Zero tail of each slot
    localparam int FRAME_CYCLES = 4 * SLOT_BITS;            // Two slots, two clk per sclk
    localparam int FRAME_CNT_W  = $clog2(FRAME_CYCLES);

endpackage

// File: hdl/synth_pkg.sv
package synth_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_VOICES = 2;
    localparam int WR_CREDITS = 4;                      // Queue depth, power of two
    localparam int WR_PTR_W   = $clog2(WR_CREDITS);
    localparam int WR_CNT_W   = $clog2(WR_CREDITS + 1);
    localparam int ADDR_W     = 4;
    localparam int DATA_W     = 16;
    localparam int PHASE_W    = 16;
    localparam int VOL_W      = 4;
    localparam int PAN_W      = 2 * NUM_VOICES;         // Left/right bit per voice
    localparam int CONTRIB_W  = PHASE_W + VOL_W + 1;    // Wave times unsigned volume

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map and opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [ADDR_W-1:0] {
        REG_V0_INC = 4'd0,
        REG_V0_CTL = 4'd1,  // [1:0] wave, [5:2] volume
        REG_V1_INC = 4'd2,
        REG_V1_CTL = 4'd3,
        REG_PAN    = 4'd4   // [0] v0 L, [1] v0 R, [2] v1 L, [3] v1 R
    } reg_addr_e;

    typedef enum logic [1:0] {
        WAVE_OFF,
        WAVE_SQUARE,
        WAVE_SAW,
        WAVE_TRIANGLE
    } wave_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;    // Raw, may be unmapped
        logic [DATA_W-1:0] data;
    } host_write_t;

    typedef struct packed {
        logic [PHASE_W-1:0] inc;
        wave_e              wave;
        logic [VOL_W-1:0]   volume;
    } voice_cfg_t;

endpackage
